// ==== dv/la32_golden.hex ====
// Word 0 is the image length, then the image from 1c000000, four words a line
// Then trace records of pc, register number and write data, two a line, ended by pc ffffffff
0000002b
1438000c 02848c04 02bfec05 15000026
00101487 00111488 001210a9 001290aa
0014188b 001490ed 001510ce 001590af
00409090 0044a0d1 0048a0d2 02815480
00101c13 2982918e 28829194 2982a18f
2882a195 580008f3 02800416 5c0008f3
02800816 5c000885 02800c16 58000885
02801017 50000800 02801417 54000c00
02801818 02801c18 4c00959a 0280201b
0280241b 4c001c3c 0280281d 0010683e
50000000 80001123 fffffed8
1c000000 0c 1c000000   1c000004 04 00000123
1c000008 05 fffffffb   1c00000c 06 80001000
1c000010 07 0000011e   1c000014 08 00000128
1c000018 09 00000001   1c00001c 0a 00000000
1c000020 0b 7fffeedc   1c000024 0d 00000102
1c000028 0e 80001123   1c00002c 0f fffffed8
1c000030 10 00001230   1c000034 11 00800010
1c000038 12 ff800010   1c00003c 00 00000178
1c000040 13 0000011e   1c000048 14 80001123
1c000050 15 fffffed8   1c000060 16 00000002
1c000070 17 00000004   1c00007c 01 1c000080
1c000088 1a 1c00008c   1c000094 1c 1c000098
1c00009c 1e 3800010c   ffffffff 00 00000000

// ==== vlog.f ====
hw/la32_pkg.sv
hw/la32_decode.sv
hw/la32_regfile.sv
hw/la32_alu.sv
hw/la32_core.sv
hw/la32_top.sv
dv/la32_tb_sva.sv
dv/la32_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := la32_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/la32_tb.sv ====
`timescale 1ns/10ps

module la32_tb;

    localparam logic [31:0] IMG_BASE = 32'h1c00_0000;

    logic                clk   = 1'b0;
    logic                reset = 1'b1;
    la32_pkg::ibus_req_t ibus_req;
    la32_pkg::wb_rsp_t   ibus_rsp = '0;
    la32_pkg::dbus_req_t dbus_req;
    la32_pkg::wb_rsp_t   dbus_rsp = '0;
    la32_pkg::trace_t    trace;

    logic [31:0] golden [256];
    logic [31:0] mem [256];
    logic [1:0]  ibus_wait   = 2'd0;
    logic [1:0]  dbus_wait   = 2'd0;
    integer      seed        = 32'h38d7;
    int          img_len     = 0;
    int          cycle_limit = 0;
    int          cycle_count = 0;
    int          trace_count = 0;   // Golden records matched so far
    int          store_count = 0;

    la32_top DUT (
        .clk      (clk),
        .reset    (reset),
        .ibus_req (ibus_req),
        .ibus_rsp (ibus_rsp),
        .dbus_req (dbus_req),
        .dbus_rsp (dbus_rsp),
        .trace    (trace)
    );

    bind la32_core la32_tb_sva u_sva (
        .clk      (clk),
        .reset    (reset),
        .ibus_req (ibus_req),
        .ibus_rsp (ibus_rsp),
        .dbus_req (dbus_req),
        .dbus_rsp (dbus_rsp),
        .trace    (trace)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    initial begin
        $readmemh("dv/la32_golden.hex", golden);
        img_len     = golden[0];
        cycle_limit = 16 + 12 * img_len;   // Forward branches only, so each word runs at most once
        repeat (16) @(posedge clk);
        reset <= 1'b0;
    end

    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        logic [31:0] addr;
        addr = IMG_BASE | {22'd0, idx, 2'b00};
        return {addr[15:0], addr[31:16]} ^ 32'h5a5a_5a5a;
    endfunction

    task automatic stop_on_error();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_end();
        if (store_count > 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("The program ended without a single store on the data bus");
            stop_on_error();
        end
    endtask

    task automatic check_trace(input la32_pkg::trace_t got);
        la32_pkg::trace_t exp;
        int               base;
        base      = img_len + 1 + 3 * trace_count;
        exp.valid = 1'b1;
        exp.pc    = golden[8'(base)];
        exp.wnum  = golden[8'(base + 1)][4:0];
        exp.wdata = golden[8'(base + 2)];
        if (exp.pc == 32'hffff_ffff) begin
            $display("Register write at %0t comes after the last golden trace record", $time);
            stop_on_error();
        end else if (got !== exp) begin
            $display("Fail at %0t: trace pc %h wnum %0d wdata %h, expected pc %h wnum %0d wdata %h",
                     $time, got.pc, got.wnum, got.wdata, exp.pc, exp.wnum, exp.wdata);
            stop_on_error();
        end
        trace_count = trace_count + 1;
    endtask

    // Store target must lie in the image, whose word there is the value expected
    task automatic check_bus(input la32_pkg::dbus_req_t req);
        logic [31:0] offs;
        offs = req.adr - IMG_BASE;
        if (offs[1:0] != 2'b00 || (offs >> 2) >= 32'(img_len)) begin
            $display("Store at %0t goes to address %h outside the golden image", $time, req.adr);
            stop_on_error();
        end else if (req.dat !== golden[8'((offs >> 2) + 1)]) begin
            $display("Fail at %0t: dbus_req.dat %h, expected %h at address %h",
                     $time, req.dat, golden[8'((offs >> 2) + 1)], req.adr);
            stop_on_error();
        end
    endtask

    // ******************************
    // Wishbone slave memory
    // ******************************

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 256; i++) begin
                mem[8'(i)] <= (i < img_len) ? golden[8'(i + 1)] : fill_word(8'(i));
            end
            ibus_rsp.ack <= 1'b0;
            dbus_rsp.ack <= 1'b0;
        end else begin
            if (ibus_req.stb && !ibus_rsp.ack) begin
                if (ibus_wait == 2'd0) begin
                    ibus_rsp.ack <= 1'b1;
                    ibus_rsp.dat <= mem[ibus_req.adr[9:2]];
                    ibus_wait    <= 2'($random(seed));
                end else begin
                    ibus_wait <= ibus_wait - 2'd1;
                end
            end else begin
                ibus_rsp.ack <= 1'b0;   // Master drops stb on the edge it takes ack
            end
            if (dbus_req.stb && !dbus_rsp.ack) begin
                if (dbus_wait == 2'd0) begin
                    dbus_rsp.ack <= 1'b1;
                    dbus_rsp.dat <= mem[dbus_req.adr[9:2]];
                    dbus_wait    <= 2'($random(seed));
                    if (dbus_req.we) begin
                        check_bus(dbus_req);
                        store_count = store_count + 1;
                        mem[dbus_req.adr[9:2]] <= dbus_req.dat;
                    end
                end else begin
                    dbus_wait <= dbus_wait - 2'd1;
                end
            end else begin
                dbus_rsp.ack <= 1'b0;
            end
        end
    end

    // ******************************
    // Trace check and timeout
    // ******************************

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles with %0d trace records matched",
                     cycle_limit, trace_count);
            stop_on_error();
        end else if (DUT.u_core.u_sva.fail_count != 0) begin
            $display("A bus or trace protocol assertion failed before %0t", $time);
            stop_on_error();
        end else if (!reset && trace.valid) begin
            check_trace(trace);
            if (golden[8'(img_len + 1 + 3 * trace_count)] == 32'hffff_ffff) begin
                report_end();
            end
        end
    end

endmodule

// ==== dv/la32_tb_sva.sv ====
`timescale 1ns/10ps

module la32_tb_sva (
    input logic                clk,
    input logic                reset,
    input la32_pkg::ibus_req_t ibus_req,
    input la32_pkg::wb_rsp_t   ibus_rsp,
    input la32_pkg::dbus_req_t dbus_req,
    input la32_pkg::wb_rsp_t   dbus_rsp,
    input la32_pkg::trace_t    trace
);

    int fail_count = 0;     // Assertion failures seen so far

    ibus_stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
        ibus_req.stb |-> ibus_req.cyc) else begin
        fail_count = fail_count + 1;
        $error("ibus stb high without cyc");
    end

    dbus_stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
        dbus_req.stb |-> dbus_req.cyc) else begin
        fail_count = fail_count + 1;
        $error("dbus stb high without cyc");
    end

    // A request waiting for ack keeps every bus output
    ibus_hold: assert property (@(posedge clk) disable iff (reset)
        ibus_req.stb && !ibus_rsp.ack |=> ibus_req.stb && $stable(ibus_req.adr))
        else begin
        fail_count = fail_count + 1;
        $error("ibus request changed before ack");
    end

    dbus_hold: assert property (@(posedge clk) disable iff (reset)
        dbus_req.stb && !dbus_rsp.ack |=> dbus_req.stb && $stable(dbus_req.adr)
            && $stable(dbus_req.dat) && $stable(dbus_req.we))
        else begin
        fail_count = fail_count + 1;
        $error("dbus request changed before ack");
    end

    one_port_active: assert property (@(posedge clk) disable iff (reset)
        !(ibus_req.cyc && dbus_req.cyc)) else begin
        fail_count = fail_count + 1;
        $error("Both Wishbone ports active together");
    end

    trace_single: assert property (@(posedge clk) disable iff (reset)
        trace.valid |=> !trace.valid) else begin
        fail_count = fail_count + 1;
        $error("trace valid on two cycles in a row");
    end

endmodule

// ==== hw/la32_top.sv ====
`timescale 1ns/10ps

module la32_top #(
    parameter logic [31:0] reset_pc = 32'h1c00_0000
) (
    input  logic                clk,
    input  logic                reset,
    output la32_pkg::ibus_req_t ibus_req,
    input  la32_pkg::wb_rsp_t   ibus_rsp,
    output la32_pkg::dbus_req_t dbus_req,
    input  la32_pkg::wb_rsp_t   dbus_rsp,
    output la32_pkg::trace_t    trace
);

    // ******************************
    // Processor core
    // ******************************

    // Both memories sit outside, on the two Wishbone ports
    la32_core #(
        .reset_pc (reset_pc)
    ) u_core (
        .clk      (clk),
        .reset    (reset),
        .ibus_req (ibus_req),
        .ibus_rsp (ibus_rsp),
        .dbus_req (dbus_req),
        .dbus_rsp (dbus_rsp),
        .trace    (trace)
    );

endmodule

// ==== hw/la32_core.sv ====
`timescale 1ns/10ps

module la32_core #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  logic                clk,
    input  logic                reset,
    output la32_pkg::ibus_req_t ibus_req,
    input  la32_pkg::wb_rsp_t   ibus_rsp,
    output la32_pkg::dbus_req_t dbus_req,
    input  la32_pkg::wb_rsp_t   dbus_rsp,
    output la32_pkg::trace_t    trace
);

    typedef enum logic [2:0] {
        S_FETCH, S_DECODE, S_EXEC, S_MEM, S_WB
    } state_e;

    state_e           state;
    logic             run;          // Low for the first cycle out of reset
    logic [31:0]      pc;
    logic [31:0]      inst_pc;
    la32_pkg::inst_u  ir;
    la32_pkg::ctrl_t  dec_ctrl;
    la32_pkg::ctrl_t  ctrl_q;
    logic [31:0]      src1_q;
    logic [31:0]      src2_q;
    logic [31:0]      rkd_q;
    logic [31:0]      res_q;
    logic [31:0]      load_q;

    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic [31:0] alu_result;
    logic [31:0] br_target;
    logic        br_taken;
    logic        fetch_done;
    logic        mem_done;
    logic        rf_we;
    logic [31:0] wb_data;

    la32_decode u_decode (
        .inst (ir),
        .ctrl (dec_ctrl)
    );

    la32_regfile u_regfile (
        .clk    (clk),
        .raddr1 (dec_ctrl.raddr1),
        .rdata1 (rdata1),
        .raddr2 (dec_ctrl.raddr2),
        .rdata2 (rdata2),
        .we     (rf_we),
        .waddr  (ctrl_q.dest),
        .wdata  (wb_data)
    );

    la32_alu u_alu (
        .alu_op     (ctrl_q.alu_op),
        .alu_src1   (src1_q),
        .alu_src2   (src2_q),
        .alu_result (alu_result)
    );

    // ******************************
    // Branch resolution in decode
    // ******************************

    always_comb begin
        case (dec_ctrl.br_kind)
            la32_pkg::BR_B, la32_pkg::BR_BL, la32_pkg::BR_JIRL: br_taken = 1'b1;
            la32_pkg::BR_BEQ: br_taken = rdata1 == rdata2;
            la32_pkg::BR_BNE: br_taken = rdata1 != rdata2;
            default:          br_taken = 1'b0;
        endcase
    end

    assign br_target = ((dec_ctrl.br_kind == la32_pkg::BR_JIRL) ? rdata1 : pc)
                       + dec_ctrl.br_offs;

    assign fetch_done = ibus_req.stb && ibus_rsp.ack;
    assign mem_done   = dbus_req.stb && dbus_rsp.ack;

    // ******************************
    // State machine and pc
    // ******************************

    always_ff @(posedge clk) begin
        if (reset) begin
            run   <= 1'b0;
            state <= S_FETCH;
            pc    <= reset_pc;
        end else begin
            run <= 1'b1;
            case (state)
                S_FETCH: if (fetch_done) state <= S_DECODE;
                S_DECODE: begin
                    pc <= br_taken ? br_target : pc + 32'd4;
                    if (dec_ctrl.br_kind inside {la32_pkg::BR_B, la32_pkg::BR_BEQ,
                                                 la32_pkg::BR_BNE}) begin
                        state <= S_FETCH;
                    end else begin
                        state <= S_EXEC;
                    end
                end
                S_EXEC: state <= (ctrl_q.mem_re || ctrl_q.mem_we) ? S_MEM : S_WB;
                S_MEM: begin
                    if (mem_done) begin
                        state <= ctrl_q.mem_re ? S_WB : S_FETCH;
                    end
                end
                default: state <= S_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            S_FETCH: if (fetch_done) ir <= ibus_rsp.dat;
            S_DECODE: begin
                inst_pc <= pc;
                ctrl_q  <= dec_ctrl;
                src1_q  <= dec_ctrl.src1_is_pc ? pc : rdata1;
                src2_q  <= dec_ctrl.src2_is_imm ? dec_ctrl.imm : rdata2;
                rkd_q   <= rdata2;
            end
            S_EXEC: res_q <= alu_result;
            S_MEM:  if (mem_done) load_q <= dbus_rsp.dat;
            default: ;
        endcase
    end

    // Both masters hold their outputs from state alone, so they stay steady until ack
    always_comb begin
        ibus_req.cyc = run && state == S_FETCH;
        ibus_req.stb = run && state == S_FETCH;
        ibus_req.adr = pc;

        dbus_req.cyc = state == S_MEM;
        dbus_req.stb = state == S_MEM;
        dbus_req.we  = state == S_MEM && ctrl_q.mem_we;
        dbus_req.adr = res_q;
        dbus_req.dat = rkd_q;
    end

    assign rf_we   = state == S_WB && ctrl_q.gr_we;
    assign wb_data = ctrl_q.mem_re ? load_q : res_q;

    assign trace.valid = rf_we;
    assign trace.pc    = inst_pc;
    assign trace.wnum  = ctrl_q.dest;   // Writes to r0 still reported
    assign trace.wdata = wb_data;

endmodule

// ==== hw/la32_alu.sv ====
`timescale 1ns/10ps

module la32_alu (
    input  la32_pkg::alu_op_e alu_op,
    input  logic [31:0]       alu_src1,
    input  logic [31:0]       alu_src2,
    output logic [31:0]       alu_result
);

    logic [31:0] sum;
    logic [31:0] diff;
    logic [4:0]  shamt;
    logic        lt_signed;
    logic        lt_unsigned;

    assign sum   = alu_src1 + alu_src2;
    assign diff  = alu_src1 - alu_src2;
    assign shamt = alu_src2[4:0];

    assign lt_signed   = $signed(alu_src1) < $signed(alu_src2);
    assign lt_unsigned = alu_src1 < alu_src2;

    always_comb begin
        case (alu_op)
            la32_pkg::ALU_ADD:  alu_result = sum;
            la32_pkg::ALU_SUB:  alu_result = diff;
            la32_pkg::ALU_SLT:  alu_result = {31'd0, lt_signed};
            la32_pkg::ALU_SLTU: alu_result = {31'd0, lt_unsigned};
            la32_pkg::ALU_AND:  alu_result = alu_src1 & alu_src2;
            la32_pkg::ALU_NOR:  alu_result = ~(alu_src1 | alu_src2);
            la32_pkg::ALU_OR:   alu_result = alu_src1 | alu_src2;
            la32_pkg::ALU_XOR:  alu_result = alu_src1 ^ alu_src2;
            la32_pkg::ALU_SLL:  alu_result = alu_src1 << shamt;
            la32_pkg::ALU_SRL:  alu_result = alu_src1 >> shamt;
            la32_pkg::ALU_SRA:  alu_result = $unsigned($signed(alu_src1) >>> shamt);
            la32_pkg::ALU_LUI:  alu_result = alu_src2;   // Immediate already shifted in decode
            default:            alu_result = sum;
        endcase
    end

endmodule

// ==== hw/la32_regfile.sv ====
`timescale 1ns/10ps

module la32_regfile (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    output logic [31:0] rdata1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] rf [32];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            rf[waddr] <= wdata;
        end
    end

    // Entry 0 is never written, so its read is forced to zero
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : rf[raddr2];

endmodule

// ==== hw/la32_decode.sv ====
`timescale 1ns/10ps

module la32_decode (
    input  la32_pkg::inst_u inst,
    output la32_pkg::ctrl_t ctrl
);

    logic        is_3r;
    logic        is_shift;
    logic [31:0] si12;
    logic [31:0] ui5;
    logic [31:0] offs16;
    logic [31:0] offs26;

    assign is_3r    = inst.r3.op_31_26 == 6'h00 && inst.r3.op_25_22 == 4'h0
                      && inst.r3.op_21_20 == 2'h1;
    assign is_shift = inst.r3.op_31_26 == 6'h00 && inst.r3.op_25_22 == 4'h1
                      && inst.r3.op_21_20 == 2'h0;

    assign si12   = {{20{inst.ri12.i12[11]}}, inst.ri12.i12};
    assign ui5    = {27'd0, inst.ri12.i12[4:0]};
    assign offs16 = {{14{inst.ri16.i16[15]}}, inst.ri16.i16, 2'b00};
    assign offs26 = {{4{inst.i26.i26_hi[9]}}, inst.i26.i26_hi, inst.i26.i26_lo, 2'b00};

    always_comb begin
        ctrl         = '0;              // No-op unless a match below
        ctrl.raddr1  = inst.r3.rj;
        ctrl.raddr2  = inst.r3.rk;
        ctrl.dest    = inst.r3.rd;
        ctrl.imm     = si12;
        ctrl.br_offs = offs16;

        if (is_3r) begin
            ctrl.gr_we = 1'b1;
            case (inst.r3.op_19_15)
                5'h00:   ctrl.alu_op = la32_pkg::ALU_ADD;
                5'h02:   ctrl.alu_op = la32_pkg::ALU_SUB;
                5'h04:   ctrl.alu_op = la32_pkg::ALU_SLT;
                5'h05:   ctrl.alu_op = la32_pkg::ALU_SLTU;
                5'h08:   ctrl.alu_op = la32_pkg::ALU_NOR;
                5'h09:   ctrl.alu_op = la32_pkg::ALU_AND;
                5'h0a:   ctrl.alu_op = la32_pkg::ALU_OR;
                5'h0b:   ctrl.alu_op = la32_pkg::ALU_XOR;
                default: ctrl.gr_we  = 1'b0;
            endcase
        end else if (is_shift) begin
            ctrl.gr_we       = 1'b1;
            ctrl.src2_is_imm = 1'b1;
            ctrl.imm         = ui5;
            case (inst.r3.op_19_15)
                5'h01:   ctrl.alu_op = la32_pkg::ALU_SLL;
                5'h09:   ctrl.alu_op = la32_pkg::ALU_SRL;
                5'h11:   ctrl.alu_op = la32_pkg::ALU_SRA;
                default: ctrl.gr_we  = 1'b0;
            endcase
        end else begin
            case (inst.r3.op_31_26)
                6'h00: if (inst.r3.op_25_22 == 4'ha) begin     // addi.w
                    ctrl.gr_we       = 1'b1;
                    ctrl.src2_is_imm = 1'b1;
                end
                6'h05: if (inst.ri20.opcode == 7'h0a) begin    // lu12i.w
                    ctrl.alu_op      = la32_pkg::ALU_LUI;
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.imm         = {inst.ri20.i20, 12'd0};
                    ctrl.gr_we       = 1'b1;
                end
                6'h0a: begin
                    ctrl.src2_is_imm = 1'b1;
                    if (inst.r3.op_25_22 == 4'h2) begin        // ld.w
                        ctrl.mem_re = 1'b1;
                        ctrl.gr_we  = 1'b1;
                    end else if (inst.r3.op_25_22 == 4'h6) begin
                        ctrl.mem_we = 1'b1;
                        ctrl.raddr2 = inst.r3.rd;              // Store data comes from rd
                    end
                end
                6'h13: begin
                    ctrl.br_kind     = la32_pkg::BR_JIRL;
                    ctrl.src1_is_pc  = 1'b1;
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.imm         = 32'd4;
                    ctrl.gr_we       = 1'b1;
                end
                6'h14: begin
                    ctrl.br_kind = la32_pkg::BR_B;
                    ctrl.br_offs = offs26;
                end
                6'h15: begin
                    ctrl.br_kind     = la32_pkg::BR_BL;
                    ctrl.br_offs     = offs26;
                    ctrl.src1_is_pc  = 1'b1;
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.imm         = 32'd4;
                    ctrl.dest        = 5'd1;
                    ctrl.gr_we       = 1'b1;
                end
                6'h16: begin
                    ctrl.br_kind = la32_pkg::BR_BEQ;
                    ctrl.raddr2  = inst.r3.rd;
                end
                6'h17: begin
                    ctrl.br_kind = la32_pkg::BR_BNE;
                    ctrl.raddr2  = inst.r3.rd;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== hw/la32_pkg.sv ====
package la32_pkg;

    // ******************************
    // Instruction word views
    // ******************************

    typedef struct packed {
        logic [5:0] op_31_26;
        logic [3:0] op_25_22;
        logic [1:0] op_21_20;
        logic [4:0] op_19_15;
        logic [4:0] rk;
        logic [4:0] rj;
        logic [4:0] rd;
    } fmt_r3_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] i12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_ri12_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] i16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_ri16_t;

    typedef struct packed {
        logic [6:0]  opcode;
        logic [19:0] i20;
        logic [4:0]  rd;
    } fmt_ri20_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] i26_lo;    // Offset bits 15:0 sit above the high part
        logic [9:0]  i26_hi;
    } fmt_i26_t;

    typedef union packed {
        fmt_r3_t   r3;
        fmt_ri12_t ri12;
        fmt_ri16_t ri16;
        fmt_ri20_t ri20;
        fmt_i26_t  i26;
    } inst_u;

    // ******************************
    // Control and bus bundles
    // ******************************

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_B, BR_BL, BR_BEQ, BR_BNE, BR_JIRL
    } br_kind_e;

    typedef struct packed {
        alu_op_e     alu_op;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic [31:0] imm;
        br_kind_e    br_kind;
        logic [31:0] br_offs;
        logic [4:0]  raddr1;
        logic [4:0]  raddr2;
        logic [4:0]  dest;
        logic        gr_we;
        logic        mem_re;
        logic        mem_we;
    } ctrl_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic [31:0] adr;
    } ibus_req_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
    } dbus_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  wnum;
        logic [31:0] wdata;
    } trace_t;

endpackage
